// ==== hdl/adc_capture_pkg.sv ====
// ================================================
// Shared types for the multi-channel ADC capture front end.
// Modules import what they use inside their bodies.
// ================================================
`default_nettype none

package adc_capture_pkg;

   // phases of one MCLK frame, stepped by the frame sequencer
   // reset_wait only occurs between reset and the first frame boundary
   typedef enum logic [2:0] {
      reset_wait,
      start,
      convert,
      sync_window,
      acquire,
      idle_wait
   } frame_state_t;

   // capture_clk cycle within a frame, so frames may be up to 256 cycles
   typedef logic [7:0] cycle_count_t;

   // bit position inside one converter word, words of up to 64 bits
   typedef logic [5:0] bit_index_t;

   // converter number on the output stream, at most 16 converters
   typedef logic [3:0] channel_index_t;

endpackage

`default_nettype wire

// ==== hdl/adc_pin_driver.sv ====
// ================================================
// Registered MCLK, SCKA and SYNC for all converters,
// plus the shift strobe and the end-of-word pulse
// that drive every channel shifter.
// ================================================
`timescale 1ns/10ps
`default_nettype none

module adc_pin_driver #(
   parameter int sample_bits    = 24,
   parameter int bits_per_frame = 6
) (
   input  logic                         capture_clk,
   input  logic                         reset,
   input  adc_capture_pkg::frame_state_t state,
   input  adc_capture_pkg::cycle_count_t frame_cycle,
   output logic                         adc_mclk,
   output logic                         adc_scka,
   output logic                         adc_sync,
   output logic                         shift_strobe,
   output logic                         word_done
);
   import adc_capture_pkg::*;

   localparam bit_index_t msb_index = bit_index_t'(sample_bits - 1);

   logic       window_parity;
   logic       first_half;
   logic       sync_gate;
   bit_index_t bits_left;

   // remember the counter parity of the first cycle after conversion
   // each bit slot after that starts on this parity, whatever convert_cycles is
   always_ff @(posedge capture_clk) begin
      if (state == start || state == convert) begin
         window_parity <= ~frame_cycle[0];
      end
   end

   assign first_half = (frame_cycle[0] == window_parity);

   // pins come from flops so no runt pulse can reach the converters
   // SCKA is high in the first half of each two-cycle bit slot
   always_ff @(posedge capture_clk) begin
      if (reset) begin
         adc_mclk <= 1'b0;
         adc_scka <= 1'b0;
         adc_sync <= 1'b0;
      end else begin
         adc_mclk <= (state == start) || (state == convert);
         adc_scka <= (state == acquire) && !sync_gate && first_half;
         adc_sync <= (state == sync_window) && sync_gate && first_half;
      end
   end

   // the MSB is already on SDOA when SYNC falls, so SYNC clocks it in
   // and the first SCKA pulse of that word is held back by the gate
   assign shift_strobe = adc_scka || adc_sync;

   // the gate stays set from the end of a word until the next acquire phase
   always_ff @(posedge capture_clk) begin
      if (reset || word_done) begin
         sync_gate <= 1'b1;
      end else if (state == acquire) begin
         sync_gate <= 1'b0;
      end
   end

   // counts down through the word across several frames
   // SYNC restarts the count so a word always begins at its MSB
   always_ff @(posedge capture_clk) begin
      if (reset) begin
         bits_left <= msb_index;
         word_done <= 1'b0;
      end else begin
         word_done <= adc_scka && (bits_left == '0);
         if (adc_sync) begin
            bits_left <= msb_index - 1'b1;
         end else if (adc_scka) begin
            bits_left <= (bits_left == '0) ? msb_index : bits_left - 1'b1;
         end
      end
   end

   // a word has to end on a frame boundary and fit the bit counter
   a_word_split: assert property (@(posedge capture_clk)
      (sample_bits % bits_per_frame == 0) && (sample_bits <= 64))
      else $error("sample_bits must be a multiple of bits_per_frame");

   // SCKA may only move while the sequencer is acquiring
   a_scka_in_acquire: assert property (@(posedge capture_clk) disable iff (reset)
      $changed(adc_scka) |-> $past(state) == acquire)
      else $error("SCKA toggled outside the acquire phase");

endmodule

`default_nettype wire

// ==== hdl/channel_shifter.sv ====
// ================================================
// One converter's input shift register and its hold
// register, which is one stage of the unload chain.
// ================================================
`timescale 1ns/10ps
`default_nettype none

module channel_shifter #(
   parameter int sample_bits = 24
) (
   input  logic                   capture_clk,
   input  logic                   sdo,
   input  logic                   shift_strobe,
   input  logic                   word_done,
   input  logic                   advance,
   input  logic [sample_bits-1:0] next_hold,
   output logic [sample_bits-1:0] hold
);

   logic [sample_bits-1:0] shift_reg;

   // bits arrive MSB first, so each new bit enters at the bottom
   always_ff @(posedge capture_clk) begin
      if (shift_strobe) begin
         shift_reg <= {shift_reg[sample_bits-2:0], sdo};
      end
   end

   // the hold stage frees the shift register for the next word
   // while the previous set is still being unloaded
   // a new set wins over a pending advance and replaces the old words
   always_ff @(posedge capture_clk) begin
      if (word_done) begin
         hold <= shift_reg;
      end else if (advance) begin
         hold <= next_hold;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/frame_sequencer.sv ====
// ================================================
// Frame timer and phase FSM shared by all converters.
// Counts capture_clk cycles per MCLK frame and steps
// through convert, sync window and acquire phases.
// ================================================
`timescale 1ns/10ps
`default_nettype none

module frame_sequencer #(
   parameter int frame_cycles   = 32,
   parameter int convert_cycles = 12,
   parameter int bits_per_frame = 6
) (
   input  logic                         capture_clk,
   input  logic                         reset,
   output adc_capture_pkg::frame_state_t state,
   output adc_capture_pkg::cycle_count_t frame_cycle
);
   import adc_capture_pkg::*;

   // counts on which each fixed phase ends
   // the sync window is always two cycles and each bit slot is two cycles
   localparam cycle_count_t frame_last   = cycle_count_t'(frame_cycles - 1);
   localparam cycle_count_t convert_last = cycle_count_t'(convert_cycles - 1);
   localparam cycle_count_t sync_last    = cycle_count_t'(convert_cycles + 1);
   localparam cycle_count_t acquire_last =
      cycle_count_t'(convert_cycles + 1 + 2 * bits_per_frame);

   logic frame_end;
   logic convert_end;
   logic sync_end;
   logic acquire_end;

   assign frame_end   = (frame_cycle == frame_last);
   assign convert_end = (frame_cycle == convert_last);
   assign sync_end    = (frame_cycle == sync_last);
   assign acquire_end = (frame_cycle == acquire_last);

   // free-running frame counter, it never stops once reset is released
   always_ff @(posedge capture_clk) begin
      if (reset || frame_end) begin
         frame_cycle <= '0;
      end else begin
         frame_cycle <= frame_cycle + 1'b1;
      end
   end

   // the FSM only produces the state, all pin timing is derived from it
   // start is entered on the wrap so that start always sits on count 0
   always_ff @(posedge capture_clk) begin
      if (reset) begin
         state <= reset_wait;
      end else begin
         case (state)
            reset_wait: begin
               if (frame_end) state <= start;
            end
            // a one-cycle conversion goes straight on to the sync window
            start: begin
               state <= convert_end ? sync_window : convert;
            end
            convert: begin
               if (convert_end) state <= sync_window;
            end
            sync_window: begin
               if (sync_end) state <= acquire;
            end
            // with no spare cycles the next frame starts right after acquire
            acquire: begin
               if (acquire_end) state <= frame_end ? start : idle_wait;
            end
            idle_wait: begin
               if (frame_end) state <= start;
            end
            default: begin
               state <= reset_wait;
            end
         endcase
      end
   end

   // conversion, sync window and every bit slot have to fit in one frame
   a_frame_fits: assert property (@(posedge capture_clk)
      convert_cycles + 2 + 2 * bits_per_frame <= frame_cycles)
      else $error("frame too short for convert, sync and acquire phases");

   // every state change is one of the legal steps of the frame
   a_state_order: assert property (@(posedge capture_clk) disable iff (reset)
      $changed(state) |->
         ($past(state) == reset_wait  && state == start) ||
         ($past(state) == start       && state inside {convert, sync_window}) ||
         ($past(state) == convert     && state == sync_window) ||
         ($past(state) == sync_window && state == acquire) ||
         ($past(state) == acquire     && state inside {idle_wait, start}) ||
         ($past(state) == idle_wait   && state == start))
      else $error("frame state stepped out of order");

endmodule

`default_nettype wire

// ==== hdl/multi_adc_capture.sv ====
// ================================================
// Capture front end for parallel LTC2512-style ADCs.
// One sequencer and pin driver serve all converters;
// each converter has its own shifter in the unload chain.
// ================================================
`timescale 1ns/10ps
`default_nettype none

module multi_adc_capture #(
   parameter int num_channels   = 4,
   parameter int sample_bits    = 24,
   parameter int frame_cycles   = 32,
   parameter int convert_cycles = 12,
   parameter int bits_per_frame = 6
) (
   input  logic                           capture_clk,
   input  logic                           reset,
   input  logic [num_channels-1:0]        adc_sdoa,
   output logic                           adc_mclk,
   output logic                           adc_scka,
   output logic                           adc_sync,
   input  logic                           out_ready,
   output logic                           out_valid,
   output adc_capture_pkg::channel_index_t out_channel,
   output logic [sample_bits-1:0]         out_sample,
   output logic                           overrun
);
   import adc_capture_pkg::*;

   frame_state_t state;
   cycle_count_t frame_cycle;
   logic         shift_strobe;
   logic         word_done;
   logic         advance;

   // hold values along the unload chain, the stage past the last channel is zero
   logic [sample_bits-1:0] hold_chain [0:num_channels];

   assign hold_chain[num_channels] = '0;
   assign out_sample = hold_chain[0];

   frame_sequencer #(
      .frame_cycles   (frame_cycles),
      .convert_cycles (convert_cycles),
      .bits_per_frame (bits_per_frame)
   ) i_frame_sequencer (
      .capture_clk (capture_clk),
      .reset       (reset),
      .state       (state),
      .frame_cycle (frame_cycle)
   );

   adc_pin_driver #(
      .sample_bits    (sample_bits),
      .bits_per_frame (bits_per_frame)
   ) i_adc_pin_driver (
      .capture_clk  (capture_clk),
      .reset        (reset),
      .state        (state),
      .frame_cycle  (frame_cycle),
      .adc_mclk     (adc_mclk),
      .adc_scka     (adc_scka),
      .adc_sync     (adc_sync),
      .shift_strobe (shift_strobe),
      .word_done    (word_done)
   );

   // channel 0 sits at the head of the chain and feeds the output
   for (genvar ch = 0; ch < num_channels; ch++) begin : g_channel
      channel_shifter #(
         .sample_bits (sample_bits)
      ) i_channel_shifter (
         .capture_clk  (capture_clk),
         .sdo          (adc_sdoa[ch]),
         .shift_strobe (shift_strobe),
         .word_done    (word_done),
         .advance      (advance),
         .next_hold    (hold_chain[ch+1]),
         .hold         (hold_chain[ch])
      );
   end

   word_unloader #(
      .num_channels (num_channels)
   ) i_word_unloader (
      .capture_clk (capture_clk),
      .reset       (reset),
      .word_done   (word_done),
      .out_ready   (out_ready),
      .out_valid   (out_valid),
      .out_channel (out_channel),
      .advance     (advance),
      .overrun     (overrun)
   );

endmodule

`default_nettype wire

// ==== hdl/word_unloader.sv ====
// ================================================
// Sends the held words out one channel at a time
// on a valid/ready stream and flags lost sets.
// ================================================
`timescale 1ns/10ps
`default_nettype none

module word_unloader #(
   parameter int num_channels = 4
) (
   input  logic                           capture_clk,
   input  logic                           reset,
   input  logic                           word_done,
   input  logic                           out_ready,
   output logic                           out_valid,
   output adc_capture_pkg::channel_index_t out_channel,
   output logic                           advance,
   output logic                           overrun
);
   import adc_capture_pkg::*;

   localparam channel_index_t last_channel = channel_index_t'(num_channels - 1);

   logic transfer;
   logic last_transfer;
   logic words_left;

   assign transfer      = out_valid && out_ready;
   assign last_transfer = transfer && (out_channel == last_channel);

   // true when some word of the current set is still unsent after this cycle
   assign words_left = out_valid && !last_transfer;

   // each accepted word moves the whole chain down by one channel
   // a new set reloads the chain instead, so no advance then
   assign advance = transfer && !word_done;

   // out_valid is the "set pending" flag and out_channel is the chain head
   always_ff @(posedge capture_clk) begin
      if (reset) begin
         out_valid   <= 1'b0;
         out_channel <= '0;
         overrun     <= 1'b0;
      end else if (word_done) begin
         // hold registers load on this same edge, so data and valid line up
         out_valid   <= 1'b1;
         out_channel <= '0;
         if (words_left) begin
            overrun <= 1'b1;
         end
      end else if (transfer) begin
         if (out_channel == last_channel) begin
            out_valid   <= 1'b0;
            out_channel <= '0;
         end else begin
            out_channel <= out_channel + 1'b1;
         end
      end
   end

   // under back-pressure the offered word stays put unless a new set lands
   a_hold_stable: assert property (@(posedge capture_clk) disable iff (reset)
      out_valid && !out_ready && !word_done |=> out_valid && $stable(out_channel))
      else $error("output changed while stalled");

endmodule

`default_nettype wire

// ==== multi_adc_capture.f ====
hdl/adc_capture_pkg.sv
hdl/frame_sequencer.sv
hdl/adc_pin_driver.sv
hdl/channel_shifter.sv
hdl/word_unloader.sv
hdl/multi_adc_capture.sv
testbench/adc_model.sv
testbench/tb_multi_adc_capture.sv

// ==== testbench/adc_model.sv ====
// ==================================================
// Behavioral model of the parallel converters. Each SYNC
// latches the next word per channel and puts its MSB on
// SDOA; every falling SYNC or SCKA edge moves one bit on.
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module adc_model #(
   parameter int num_channels = 4,
   parameter int sample_bits  = 24
) (
   input  logic                                adc_sync,
   input  logic                                adc_scka,
   input  logic [num_channels*sample_bits-1:0] words,
   output logic [num_channels-1:0]             adc_sdoa,
   output int                                  sync_count
);

   // words of the conversion being read out, channel 0 in the low bits
   logic [num_channels*sample_bits-1:0] latched;
   int                                  bit_pos;

   // one bit of every channel at the same position in its word
   function automatic logic [num_channels-1:0] bits_at(input int pos);
      logic [num_channels-1:0] slice;
      for (int ch = 0; ch < num_channels; ch++) begin
         slice[ch] = latched[ch*sample_bits + pos];
      end
      return slice;
   endfunction

   initial begin
      latched    = '0;
      bit_pos    = 0;
      adc_sdoa   = '0;
      sync_count = 0;
   end

   // SYNC starts a new word, and the MSB is valid before SYNC falls
   always @(posedge adc_sync) begin
      latched    = words;
      bit_pos    = sample_bits - 1;
      adc_sdoa   = bits_at(bit_pos);
      sync_count = sync_count + 1;
   end

   // the capture side takes a bit on each falling edge, so the next one follows it
   // once the word is used up the line idles low
   always @(negedge adc_sync or negedge adc_scka) begin
      if (bit_pos > 0) begin
         bit_pos  = bit_pos - 1;
         adc_sdoa = bits_at(bit_pos);
      end else begin
         adc_sdoa = '0;
      end
   end

endmodule

`default_nettype wire

// ==== testbench/tb_multi_adc_capture.sv ====
// ==================================================
// Testbench for the multi-channel ADC capture front end.
// Plays a table of word sets through the converter model,
// checks pin timing and the output stream, and stalls ready.
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module tb_multi_adc_capture;
   import adc_capture_pkg::*;

   localparam int num_channels   = 4;
   localparam int sample_bits    = 24;
   localparam int frame_cycles   = 32;
   localparam int convert_cycles = 12;
   localparam int bits_per_frame = 6;
   localparam int num_rows       = 8;
   // this row's stall outlasts a word period, so the next set overwrites it
   localparam int overrun_row    = 4;
   localparam int word_period    = frame_cycles * sample_bits / bits_per_frame;
   localparam int watchdog_ns    = (num_rows + 4) * word_period * 100;

   logic                                capture_clk;
   logic                                reset;
   logic [num_channels-1:0]             adc_sdoa;
   logic                                adc_mclk;
   logic                                adc_scka;
   logic                                adc_sync;
   logic                                out_ready;
   logic                                out_valid;
   channel_index_t                      out_channel;
   logic [sample_bits-1:0]              out_sample;
   logic                                overrun;
   logic [num_channels*sample_bits-1:0] model_words;
   int                                  sync_count;

   logic [sample_bits-1:0] row_sample [num_rows][num_channels];
   int                     row_stall [num_rows];
   integer                 seed;
   bit                     table_built;
   int                     checks;
   int                     errors;
   logic                   expect_overrun;
   int                     row;

   // pin monitor bookkeeping, counted in negedge samples
   int   cycle_no;
   int   mclk_rise_at;
   int   mclk_high;
   int   sync_at;
   int   scka_pulses;
   logic mclk_prev;
   logic scka_prev;
   logic sync_prev;
   bit   mclk_seen;
   bit   sync_seen;

   multi_adc_capture #(
      .num_channels   (num_channels),
      .sample_bits    (sample_bits),
      .frame_cycles   (frame_cycles),
      .convert_cycles (convert_cycles),
      .bits_per_frame (bits_per_frame)
   ) i_multi_adc_capture (
      .capture_clk (capture_clk),
      .reset       (reset),
      .adc_sdoa    (adc_sdoa),
      .adc_mclk    (adc_mclk),
      .adc_scka    (adc_scka),
      .adc_sync    (adc_sync),
      .out_ready   (out_ready),
      .out_valid   (out_valid),
      .out_channel (out_channel),
      .out_sample  (out_sample),
      .overrun     (overrun)
   );

   adc_model #(
      .num_channels (num_channels),
      .sample_bits  (sample_bits)
   ) i_adc_model (
      .adc_sync   (adc_sync),
      .adc_scka   (adc_scka),
      .words      (model_words),
      .adc_sdoa   (adc_sdoa),
      .sync_count (sync_count)
   );

   always #50 capture_clk = ~capture_clk;

   task automatic check_sample(input logic [sample_bits-1:0] actual, expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED out_sample: got 0x%h expected 0x%h at %0t", actual, expected, $time);
      end
   endtask

   task automatic check_channel(input channel_index_t actual, expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED out_channel: got 0x%h expected 0x%h at %0t", actual, expected, $time);
      end
   endtask

   task automatic check_flag(input string name, input logic actual, expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
      end
   endtask

   task automatic check_count(input string name, input int actual, expected);
      checks++;
      if (actual != expected) begin
         errors++;
         $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
      end
   endtask

   task automatic report_error(input string what);
      errors++;
      $display("ERROR: %s at %0t", what, $time);
   endtask

   // samples per channel and a ready stall length for each row
   task automatic build_table();
      seed = 80416;
      for (int r = 0; r < num_rows; r++) begin
         for (int ch = 0; ch < num_channels; ch++) begin
            row_sample[r][ch] = sample_bits'($random(seed));
         end
         row_stall[r] = $random(seed) & 32'h3f;
      end
      row_stall[overrun_row] = word_period + frame_cycles;
   endtask

   function automatic logic [num_channels*sample_bits-1:0] pack_row(input int r);
      logic [num_channels*sample_bits-1:0] flat;
      for (int ch = 0; ch < num_channels; ch++) begin
         flat[ch*sample_bits +: sample_bits] = row_sample[r][ch];
      end
      return flat;
   endfunction

   // called on a falling edge with out_ready high, leaves one edge after the transfer
   task automatic take_word(input channel_index_t exp_channel,
                            input logic [sample_bits-1:0] exp_sample);
      while (!out_valid) @(negedge capture_clk);
      check_channel(out_channel, exp_channel);
      check_sample(out_sample, exp_sample);
      check_flag("overrun", overrun, expect_overrun);
      @(negedge capture_clk);
   endtask

   // waits for the set of stall_row, stalls, then drains and expects data_row's words
   task automatic receive_set(input int stall_row, input int data_row);
      while (!out_valid) @(negedge capture_clk);
      check_channel(out_channel, '0);
      check_sample(out_sample, row_sample[stall_row][0]);
      repeat (row_stall[stall_row]) @(negedge capture_clk);
      out_ready = 1'b1;
      for (int ch = 0; ch < num_channels; ch++) begin
         take_word(channel_index_t'(ch), row_sample[data_row][ch]);
      end
      out_ready = 1'b0;
   endtask

   // the model latches a row on each SYNC, so the next row goes up right after
   initial begin
      wait (table_built);
      for (int r = 0; r < num_rows; r++) begin
         @(negedge capture_clk);
         model_words = pack_row(r);
         wait (sync_count == r + 1);
      end
   end

   // MCLK shape and period, one SYNC and sample_bits-1 SCKA pulses per word
   always @(negedge capture_clk) begin
      if (reset) begin
         cycle_no    = 0;
         mclk_high   = 0;
         scka_pulses = 0;
         mclk_prev   = 1'b0;
         scka_prev   = 1'b0;
         sync_prev   = 1'b0;
         mclk_seen   = 1'b0;
         sync_seen   = 1'b0;
      end else begin
         cycle_no++;
         if (out_valid && !sync_seen) begin
            report_error("out_valid raised before the first SYNC pulse");
         end
         if (adc_mclk && !mclk_prev) begin
            if (mclk_seen) begin
               check_count("adc_mclk period", cycle_no - mclk_rise_at, frame_cycles);
            end
            mclk_seen    = 1'b1;
            mclk_rise_at = cycle_no;
            mclk_high    = 0;
         end
         if (adc_mclk) begin
            mclk_high++;
         end
         if (!adc_mclk && mclk_prev) begin
            check_count("adc_mclk high cycles", mclk_high, convert_cycles);
         end
         if (adc_scka && !scka_prev) begin
            scka_pulses++;
         end
         if (adc_sync && sync_prev) begin
            report_error("adc_sync stayed high for more than one cycle");
         end
         if (adc_sync && !sync_prev) begin
            if (sync_seen) begin
               check_count("adc_sync spacing", cycle_no - sync_at, word_period);
               check_count("adc_scka pulses per word", scka_pulses, sample_bits - 1);
            end
            sync_seen   = 1'b1;
            sync_at     = cycle_no;
            scka_pulses = 0;
         end
         mclk_prev = adc_mclk;
         scka_prev = adc_scka;
         sync_prev = adc_sync;
      end
   end

   initial begin
      #(watchdog_ns);
      $display("timeout: the output stream stalled after %0d ns", watchdog_ns);
      $display("test failed");
      $finish;
   end

   initial begin
      capture_clk    = 1'b0;
      reset          = 1'b1;
      out_ready      = 1'b0;
      model_words    = '0;
      checks         = 0;
      errors         = 0;
      expect_overrun = 1'b0;
      build_table();
      table_built = 1'b1;
      repeat (10) @(negedge capture_clk);
      check_flag("adc_mclk", adc_mclk, 1'b0);
      check_flag("adc_scka", adc_scka, 1'b0);
      check_flag("adc_sync", adc_sync, 1'b0);
      check_flag("out_valid", out_valid, 1'b0);
      check_flag("overrun", overrun, 1'b0);
      reset = 1'b0;
      @(negedge capture_clk);
      check_flag("adc_mclk", adc_mclk, 1'b0);
      check_flag("out_valid", out_valid, 1'b0);
      row = 0;
      while (row < num_rows) begin
         if (row_stall[row] >= word_period) begin
            // the following set lands during the stall and replaces this one
            expect_overrun = 1'b1;
            receive_set(row, row + 1);
            row += 2;
         end else begin
            receive_set(row, row);
            row += 1;
         end
      end
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
